/* common/dmiss_pkg.sv */
package dmiss_pkg;

    localparam int PADDR_W     = 32;
    localparam int WORD_W      = 32;
    localparam int BYTES_W     = WORD_W / 8;
    localparam int LINE_WORDS  = 8;
    localparam int OFFSET_W    = 3;
    localparam int LINE_ADDR_W = 27;
    localparam int LQ_IDX_W    = 5;
    localparam int SC_IDX_W    = 3;
    // entry index width in the structs covers up to 16 entries
    localparam int ENTRY_W     = 4;
    localparam int LEN_W       = 8;

    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_data_t;
    typedef logic [LINE_WORDS-1:0][BYTES_W-1:0] line_mask_t;

    typedef struct packed {
        logic [PADDR_W-1:0]  addr;
        logic [LQ_IDX_W-1:0] lq_idx;
    } load_req_t;

    typedef struct packed {
        logic [PADDR_W-1:0]  addr;
        logic [WORD_W-1:0]   data;
        logic [BYTES_W-1:0]  mask;
        logic [SC_IDX_W-1:0] sc_idx;
    } store_req_t;

    typedef struct packed {
        logic [ENTRY_W-1:0]  entry;
        logic [LQ_IDX_W-1:0] lq_idx;
        logic [OFFSET_W-1:0] offset;
    } waiter_t;

    typedef struct packed {
        logic                   valid;
        logic [LINE_ADDR_W-1:0] line_addr;
        line_data_t             data;
        line_mask_t             mask;
        logic [SC_IDX_W-1:0]    sc_idx;
        logic [ENTRY_W-1:0]     idx;
    } head_line_t;

    typedef struct packed {
        logic [PADDR_W-1:0] addr;
        logic [LEN_W-1:0]   len;
    } ar_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } r_beat_t;

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        line_data_t             data;
        logic                   dirty;
        logic [SC_IDX_W-1:0]    sc_idx;
    } refill_t;

    typedef struct packed {
        logic [LQ_IDX_W-1:0] lq_idx;
        logic [WORD_W-1:0]   data;
    } load_resp_t;

    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA,
        FILL_MERGE,
        FILL_REFILL
    } fill_state_e;

endpackage

/* miss_queue/miss_queue.sv */
`timescale 1ns/1ps

module miss_queue #(
    parameter int MISS_ENTRIES = 4,
    parameter int WAITERS      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ren,
    input  dmiss_pkg::load_req_t  load_req,
    input  logic                  wen,
    input  dmiss_pkg::store_req_t store_req,
    input  logic                  waiter_full,
    input  logic                  head_locked,
    input  logic                  refill_done,
    output logic                  rfull,
    output logic                  wfull,
    output logic                  waiter_wen,
    output dmiss_pkg::waiter_t    new_waiter,
    output dmiss_pkg::head_line_t head_line
);
    localparam int IDX_W  = $clog2(MISS_ENTRIES);
    localparam int CNT_W  = IDX_W + 1;
    localparam int EW     = dmiss_pkg::ENTRY_W;
    localparam int LAW    = dmiss_pkg::LINE_ADDR_W;
    localparam int OW     = dmiss_pkg::OFFSET_W;

    logic [MISS_ENTRIES-1:0]        en;
    logic [LAW-1:0]                 addr [MISS_ENTRIES];
    dmiss_pkg::line_data_t          data [MISS_ENTRIES];
    dmiss_pkg::line_mask_t          mask [MISS_ENTRIES];
    logic [dmiss_pkg::SC_IDX_W-1:0] sc_idx [MISS_ENTRIES];
    logic [IDX_W-1:0]               head, tail;
    logic [CNT_W-1:0]               free_cnt;

    logic [LAW-1:0]        l_line, s_line;
    logic [OW-1:0]         l_off, s_off;
    logic                  l_hit, s_hit;
    logic [IDX_W-1:0]      l_hit_idx, s_hit_idx;
    logic                  s_locked, s_alloc, s_acc;
    logic                  l_same, l_room, l_acc, l_alloc;
    logic [IDX_W-1:0]      s_widx, l_idx;
    dmiss_pkg::line_data_t s_data;
    dmiss_pkg::line_mask_t s_mask;

    assign l_line = load_req.addr[dmiss_pkg::PADDR_W-1 -: LAW];
    assign s_line = store_req.addr[dmiss_pkg::PADDR_W-1 -: LAW];
    assign l_off  = load_req.addr[OW+1:2];
    assign s_off  = store_req.addr[OW+1:2];

    // line match that skips the head being released
    always_comb begin
        l_hit     = 1'b0;
        s_hit     = 1'b0;
        l_hit_idx = '0;
        s_hit_idx = '0;
        for (int i = 0; i < MISS_ENTRIES; i++) begin
            if (en[i] && addr[i] == l_line && !(refill_done && IDX_W'(i) == head)) begin
                l_hit     = 1'b1;
                l_hit_idx = IDX_W'(i);
            end
            if (en[i] && addr[i] == s_line) begin
                s_hit     = 1'b1;
                s_hit_idx = IDX_W'(i);
            end
        end
    end

    assign s_locked = head_locked && s_hit_idx == head;
    assign s_alloc  = wen && !s_hit && free_cnt != '0;
    assign s_acc    = wen && (s_hit ? !s_locked : free_cnt != '0);
    assign s_widx   = s_hit ? s_hit_idx : tail;

    // a load to the line the store opens this cycle shares its entry
    assign l_same  = s_alloc && l_line == s_line;
    assign l_room  = l_hit || l_same || free_cnt > CNT_W'(s_alloc);
    assign l_acc   = ren && !waiter_full && l_room;
    assign l_alloc = l_acc && !l_hit && !l_same;
    assign l_idx   = l_hit ? l_hit_idx : (l_same ? tail : tail + IDX_W'(s_alloc));

    // byte merge where a later store wins
    always_comb begin
        s_data = data[s_widx];
        s_mask = s_hit ? mask[s_widx] : '0;
        for (int b = 0; b < dmiss_pkg::BYTES_W; b++) begin
            if (store_req.mask[b]) begin
                s_data[s_off][8*b +: 8] = store_req.data[8*b +: 8];
            end
        end
        s_mask[s_off] = s_mask[s_off] | store_req.mask;
    end

    assign waiter_wen        = l_acc;
    assign new_waiter.entry  = EW'(l_idx);
    assign new_waiter.lq_idx = load_req.lq_idx;
    assign new_waiter.offset = l_off;

    assign head_line.valid     = en[head];
    assign head_line.line_addr = addr[head];
    assign head_line.data      = data[head];
    assign head_line.mask      = mask[head];
    assign head_line.sc_idx    = sc_idx[head];
    assign head_line.idx       = EW'(head);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en       <= '0;
            head     <= '0;
            tail     <= '0;
            free_cnt <= CNT_W'(MISS_ENTRIES);
            rfull    <= 1'b0;
            wfull    <= 1'b0;
        end else begin
            rfull <= ren && !l_acc;
            wfull <= wen && !s_acc;
            if (refill_done) begin
                en[head] <= 1'b0;
            end
            if (s_alloc) begin
                en[tail] <= 1'b1;
            end
            if (l_alloc) begin
                en[l_idx] <= 1'b1;
            end
            head     <= head + IDX_W'(refill_done);
            tail     <= tail + IDX_W'(s_alloc) + IDX_W'(l_alloc);
            free_cnt <= free_cnt + CNT_W'(refill_done) - CNT_W'(s_alloc) - CNT_W'(l_alloc);
        end
    end

    always_ff @(posedge clk) begin
        if (s_acc) begin
            data[s_widx]   <= s_data;
            mask[s_widx]   <= s_mask;
            sc_idx[s_widx] <= store_req.sc_idx;
        end
        if (s_alloc) begin
            addr[tail] <= s_line;
        end
        if (l_alloc) begin
            addr[l_idx]   <= l_line;
            mask[l_idx]   <= '0;
            sc_idx[l_idx] <= '0;
        end
    end

endmodule

/* rtl/load_waiter_table.sv */
`timescale 1ns/1ps

module load_waiter_table #(
    parameter int WAITERS      = 4,
    parameter int MISS_ENTRIES = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          waiter_wen,
    input  dmiss_pkg::waiter_t            new_waiter,
    input  logic [dmiss_pkg::ENTRY_W-1:0] head_idx,
    input  logic                          waiter_pop,
    output logic                          waiter_full,
    output logic                          head_waiter_valid,
    output dmiss_pkg::waiter_t            head_waiter
);
    localparam int IDX_W  = $clog2(MISS_ENTRIES);
    localparam int SLOT_W = $clog2(WAITERS);

    dmiss_pkg::waiter_t  slot [WAITERS];
    logic [WAITERS-1:0]  valid;
    // elder[i][j] set when slot j was allocated before slot i
    logic [WAITERS-1:0]  elder [WAITERS];
    logic [WAITERS-1:0]  match;
    logic [SLOT_W-1:0]   free_idx, sel_idx;

    assign waiter_full = &valid;

    always_comb begin
        free_idx = '0;
        for (int i = WAITERS - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = SLOT_W'(i);
            end
        end
    end

    // oldest slot waiting on the head entry
    always_comb begin
        for (int i = 0; i < WAITERS; i++) begin
            match[i] = valid[i] && slot[i].entry[IDX_W-1:0] == head_idx[IDX_W-1:0];
        end
        sel_idx = '0;
        for (int i = 0; i < WAITERS; i++) begin
            if (match[i] && !(|(match & elder[i]))) begin
                sel_idx = SLOT_W'(i);
            end
        end
    end

    assign head_waiter_valid = |match;
    assign head_waiter       = slot[sel_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (waiter_pop) begin
                valid[sel_idx] <= 1'b0;
            end
            if (waiter_wen) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (waiter_wen) begin
            slot[free_idx] <= new_waiter;
            for (int i = 0; i < WAITERS; i++) begin
                elder[i][free_idx] <= 1'b0;
            end
            elder[free_idx] <= valid;
        end
    end

endmodule

/* rtl/line_fill.sv */
`timescale 1ns/1ps

module line_fill (
    input  logic                  clk,
    input  logic                  rst,
    input  dmiss_pkg::head_line_t head_line,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  dmiss_pkg::r_beat_t    r_beat,
    input  logic                  refill_valid,
    input  logic                  head_waiter_valid,
    input  dmiss_pkg::waiter_t    head_waiter,
    output logic                  ar_valid,
    output dmiss_pkg::ar_req_t    ar_req,
    output logic                  refill_en,
    output dmiss_pkg::refill_t    refill,
    output logic                  head_locked,
    output logic                  refill_done,
    output logic                  waiter_pop,
    output logic                  lq_en,
    output dmiss_pkg::load_resp_t load_resp
);
    localparam int OW = dmiss_pkg::OFFSET_W;

    dmiss_pkg::fill_state_e state;
    logic [OW-1:0]          beat_cnt;
    logic                   accepted;
    dmiss_pkg::line_data_t  line_buf;
    dmiss_pkg::line_data_t  merged;

    // store bytes of the head laid over the fetched words
    always_comb begin
        merged = line_buf;
        for (int w = 0; w < dmiss_pkg::LINE_WORDS; w++) begin
            for (int b = 0; b < dmiss_pkg::BYTES_W; b++) begin
                if (head_line.mask[w][b]) begin
                    merged[w][8*b +: 8] = head_line.data[w][8*b +: 8];
                end
            end
        end
    end

    assign ar_valid    = state == dmiss_pkg::FILL_ADDR;
    assign ar_req.addr = {head_line.line_addr, {(OW + 2){1'b0}}};
    assign ar_req.len  = dmiss_pkg::LEN_W'(dmiss_pkg::LINE_WORDS - 1);

    assign head_locked = state == dmiss_pkg::FILL_MERGE || state == dmiss_pkg::FILL_REFILL;
    assign refill_en   = state == dmiss_pkg::FILL_REFILL && !accepted;

    // head is locked here, so its fields hold still
    assign refill.line_addr = head_line.line_addr;
    assign refill.data      = line_buf;
    assign refill.dirty     = |head_line.mask;
    assign refill.sc_idx    = head_line.sc_idx;

    assign waiter_pop  = state == dmiss_pkg::FILL_REFILL && accepted && head_waiter_valid;
    assign refill_done = state == dmiss_pkg::FILL_REFILL && accepted && !head_waiter_valid;
    assign lq_en       = waiter_pop;

    assign load_resp.lq_idx = head_waiter.lq_idx;
    assign load_resp.data   = line_buf[head_waiter.offset];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= dmiss_pkg::FILL_IDLE;
            beat_cnt <= '0;
            accepted <= 1'b0;
        end else begin
            case (state)
                dmiss_pkg::FILL_IDLE: begin
                    if (head_line.valid) begin
                        state <= dmiss_pkg::FILL_ADDR;
                    end
                end
                dmiss_pkg::FILL_ADDR: begin
                    beat_cnt <= '0;
                    if (ar_ready) begin
                        state <= dmiss_pkg::FILL_DATA;
                    end
                end
                dmiss_pkg::FILL_DATA: begin
                    if (r_valid) begin
                        beat_cnt <= beat_cnt + OW'(1);
                        if (r_beat.last) begin
                            state <= dmiss_pkg::FILL_MERGE;
                        end
                    end
                end
                dmiss_pkg::FILL_MERGE: begin
                    accepted <= 1'b0;
                    state    <= dmiss_pkg::FILL_REFILL;
                end
                dmiss_pkg::FILL_REFILL: begin
                    if (refill_en && refill_valid) begin
                        accepted <= 1'b1;
                    end
                    if (refill_done) begin
                        accepted <= 1'b0;
                        state    <= dmiss_pkg::FILL_IDLE;
                    end
                end
                default: state <= dmiss_pkg::FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dmiss_pkg::FILL_DATA && r_valid) begin
            line_buf[beat_cnt] <= r_beat.data;
        end
        if (state == dmiss_pkg::FILL_MERGE) begin
            line_buf <= merged;
        end
    end

endmodule

/* rtl/dmiss_top.sv */
`timescale 1ns/1ps

module dmiss_top #(
    parameter int MISS_ENTRIES = 4,
    parameter int WAITERS      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ren,
    input  dmiss_pkg::load_req_t  load_req,
    output logic                  rfull,
    input  logic                  wen,
    input  dmiss_pkg::store_req_t store_req,
    output logic                  wfull,
    output logic                  ar_valid,
    output dmiss_pkg::ar_req_t    ar_req,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  dmiss_pkg::r_beat_t    r_beat,
    output logic                  refill_en,
    output dmiss_pkg::refill_t    refill,
    input  logic                  refill_valid,
    output logic                  lq_en,
    output dmiss_pkg::load_resp_t load_resp
);
    dmiss_pkg::head_line_t head_line;
    dmiss_pkg::waiter_t    new_waiter;
    dmiss_pkg::waiter_t    head_waiter;
    logic                  waiter_wen;
    logic                  waiter_full;
    logic                  head_waiter_valid;
    logic                  head_locked;
    logic                  refill_done;
    logic                  waiter_pop;

    miss_queue #(
        .MISS_ENTRIES (MISS_ENTRIES),
        .WAITERS      (WAITERS)
    ) i_miss_queue (
        .clk         (clk),
        .rst         (rst),
        .ren         (ren),
        .load_req    (load_req),
        .wen         (wen),
        .store_req   (store_req),
        .waiter_full (waiter_full),
        .head_locked (head_locked),
        .refill_done (refill_done),
        .rfull       (rfull),
        .wfull       (wfull),
        .waiter_wen  (waiter_wen),
        .new_waiter  (new_waiter),
        .head_line   (head_line)
    );

    load_waiter_table #(
        .WAITERS      (WAITERS),
        .MISS_ENTRIES (MISS_ENTRIES)
    ) i_load_waiter_table (
        .clk               (clk),
        .rst               (rst),
        .waiter_wen        (waiter_wen),
        .new_waiter        (new_waiter),
        .head_idx          (head_line.idx),
        .waiter_pop        (waiter_pop),
        .waiter_full       (waiter_full),
        .head_waiter_valid (head_waiter_valid),
        .head_waiter       (head_waiter)
    );

    line_fill i_line_fill (
        .clk               (clk),
        .rst               (rst),
        .head_line         (head_line),
        .ar_ready          (ar_ready),
        .r_valid           (r_valid),
        .r_beat            (r_beat),
        .refill_valid      (refill_valid),
        .head_waiter_valid (head_waiter_valid),
        .head_waiter       (head_waiter),
        .ar_valid          (ar_valid),
        .ar_req            (ar_req),
        .refill_en         (refill_en),
        .refill            (refill),
        .head_locked       (head_locked),
        .refill_done       (refill_done),
        .waiter_pop        (waiter_pop),
        .lq_en             (lq_en),
        .load_resp         (load_resp)
    );

endmodule

/* dv/dmiss_tb.sv */
`timescale 1ns/1ps

module dmiss_tb;
    localparam int MAX_OPS       = 128;
    // hex words per vector line
    localparam int OP_W          = 5;
    localparam int CYCLES_PER_OP = 200;
    localparam int BEATS         = dmiss_pkg::LINE_WORDS;

    logic                  clk;
    logic                  rst;
    logic                  ren;
    dmiss_pkg::load_req_t  load_req;
    logic                  rfull;
    logic                  wen;
    dmiss_pkg::store_req_t store_req;
    logic                  wfull;
    logic                  ar_valid;
    dmiss_pkg::ar_req_t    ar_req;
    logic                  ar_ready;
    logic                  r_valid;
    dmiss_pkg::r_beat_t    r_beat;
    logic                  refill_en;
    dmiss_pkg::refill_t    refill;
    logic                  refill_valid;
    logic                  lq_en;
    dmiss_pkg::load_resp_t load_resp;

    logic [31:0]           vec [MAX_OPS*OP_W];
    int                    n_ops = 0;
    logic                  loaded = 1'b0;
    int                    refill_delay = 0;
    int                    err_cnt = 0;

    // expected refills in fill order
    logic [31:0]           exp_line [MAX_OPS];
    logic                  exp_dirty [MAX_OPS];
    logic [2:0]            exp_sc [MAX_OPS];
    dmiss_pkg::line_data_t exp_data [MAX_OPS];
    int                    n_refill = 0;
    int                    refill_seen = 0;
    int                    ar_seen = 0;

    dmiss_pkg::load_resp_t resp_q [$];
    dmiss_pkg::load_resp_t exp_resp;
    int                    rfull_exp = 0;
    int                    wfull_exp = 0;
    int                    rfull_cnt = 0;
    int                    wfull_cnt = 0;

    dmiss_top i_dmiss_top (
        .clk          (clk),
        .rst          (rst),
        .ren          (ren),
        .load_req     (load_req),
        .rfull        (rfull),
        .wen          (wen),
        .store_req    (store_req),
        .wfull        (wfull),
        .ar_valid     (ar_valid),
        .ar_req       (ar_req),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_beat       (r_beat),
        .refill_en    (refill_en),
        .refill       (refill),
        .refill_valid (refill_valid),
        .lq_en        (lq_en),
        .load_resp    (load_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory contents seen by the read channel
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string what);
        err_cnt++;
        $display("[ERROR] %s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_refill(input logic [31:0] line, input logic dirty,
                                input logic [2:0] sc, input dmiss_pkg::line_data_t data);
        check_value("refill.line_addr", {refill.line_addr, 5'b0}, line);
        check_value("refill.dirty", refill.dirty, dirty);
        check_value("refill.sc_idx", refill.sc_idx, sc);
        for (int w = 0; w < BEATS; w++) begin
            check_value($sformatf("refill.data[%0d]", w), refill.data[w], data[w]);
        end
    endtask

    // first pass over the vectors collects everything expected
    task automatic load_expectations();
        logic [31:0]           op;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           c;
        dmiss_pkg::load_resp_t resp;
        for (int i = 0; i < n_ops; i++) begin
            op = vec[i*OP_W];
            a  = vec[i*OP_W+1];
            b  = vec[i*OP_W+2];
            c  = vec[i*OP_W+3];
            case (op)
                32'h2: rfull_exp++;
                32'h4: wfull_exp++;
                32'h7: begin
                    exp_line[n_refill]  = a;
                    exp_dirty[n_refill] = b[0];
                    exp_sc[n_refill]    = c[2:0];
                    for (int w = 0; w < BEATS; w++) begin
                        exp_data[n_refill][w] = mem_word(a + 32'(4 * w));
                    end
                    n_refill++;
                end
                32'h8: exp_data[n_refill-1][a[2:0]] = b;
                32'h9: begin
                    resp.lq_idx = a[dmiss_pkg::LQ_IDX_W-1:0];
                    resp.data   = b;
                    resp_q.push_back(resp);
                end
                default: ;
            endcase
        end
    endtask

    task automatic drive_load(input logic [31:0] addr, input logic [31:0] lq,
                              input logic rejected);
        ren             = 1'b1;
        load_req.addr   = addr;
        load_req.lq_idx = lq[dmiss_pkg::LQ_IDX_W-1:0];
        @(negedge clk);
        ren = 1'b0;
        check_value("rfull", rfull, rejected);
    endtask

    task automatic drive_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] mask, input logic [31:0] sc,
                               input logic rejected);
        wen              = 1'b1;
        store_req.addr   = addr;
        store_req.data   = data;
        store_req.mask   = mask[3:0];
        store_req.sc_idx = sc[2:0];
        @(negedge clk);
        wen = 1'b0;
        check_value("wfull", wfull, rejected);
    endtask

    initial begin
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        rst       = 1'b1;
        ren       = 1'b0;
        load_req  = '0;
        wen       = 1'b0;
        store_req = '0;
        for (int i = 0; i < MAX_OPS * OP_W; i++) begin
            vec[i] = '0;
        end
        $readmemh("dv/dmiss_vectors.txt", vec);
        while (n_ops < MAX_OPS && vec[n_ops*OP_W] != 32'h0) begin
            n_ops++;
        end
        load_expectations();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("ar_valid", ar_valid, 0);
        check_value("refill_en", refill_en, 0);
        check_value("lq_en", lq_en, 0);
        check_value("rfull", rfull, 0);
        check_value("wfull", wfull, 0);
        for (int i = 0; i < n_ops; i++) begin
            op = vec[i*OP_W];
            a  = vec[i*OP_W+1];
            b  = vec[i*OP_W+2];
            c  = vec[i*OP_W+3];
            d  = vec[i*OP_W+4];
            case (op)
                32'h1: drive_load(a, b, 1'b0);
                32'h2: drive_load(a, b, 1'b1);
                32'h3: drive_store(a, b, c, d, 1'b0);
                32'h4: drive_store(a, b, c, d, 1'b1);
                32'h5: repeat (a) @(negedge clk);
                32'h6: refill_delay = int'(a);
                default: ;
            endcase
        end
        // let outstanding fills and responses drain
        while (resp_q.size() != 0 || refill_seen != n_refill) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        check_value("rfull pulses", rfull_cnt, rfull_exp);
        check_value("wfull pulses", wfull_cnt, wfull_exp);
        check_value("read requests", ar_seen, n_refill);
        if (err_cnt == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1);
        end
    end

    // memory responder
    initial begin
        int unsigned gap;
        logic [31:0] base;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_beat   = '0;
        gap = $urandom(32'h9b23_efaf);
        forever begin
            @(negedge clk);
            if (!rst && ar_valid) begin
                base = ar_req.addr;
                if (ar_seen >= n_refill) begin
                    abort_run("read request issued with no refill expected");
                end else begin
                    check_value("ar_req.addr", base, exp_line[ar_seen]);
                    check_value("ar_req.len", ar_req.len, BEATS - 1);
                    ar_seen++;
                    gap = $urandom % 4;
                    repeat (gap) @(negedge clk);
                    ar_ready = 1'b1;
                    @(negedge clk);
                    ar_ready = 1'b0;
                    for (int w = 0; w < BEATS; w++) begin
                        r_valid     = 1'b1;
                        r_beat.data = mem_word(base + 32'(4 * w));
                        r_beat.last = w == BEATS - 1;
                        @(negedge clk);
                    end
                    r_valid     = 1'b0;
                    r_beat.last = 1'b0;
                end
            end
        end
    end

    // refill acceptor that holds off for the programmed delay
    initial begin
        int idx;
        refill_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && refill_en) begin
                if (refill_seen >= n_refill) begin
                    abort_run("refill offered with none expected");
                end else begin
                    idx = refill_seen;
                    check_refill(exp_line[idx], exp_dirty[idx], exp_sc[idx], exp_data[idx]);
                    refill_seen++;
                    for (int k = 0; k < refill_delay; k++) begin
                        @(negedge clk);
                        check_value("refill_en", refill_en, 1);
                        check_value("lq_en", lq_en, 0);
                        check_refill(exp_line[idx], exp_dirty[idx], exp_sc[idx],
                                     exp_data[idx]);
                    end
                    refill_valid = 1'b1;
                    @(negedge clk);
                    refill_valid = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && rfull) begin
            rfull_cnt = rfull_cnt + 1;
        end
        if (!rst && wfull) begin
            wfull_cnt = wfull_cnt + 1;
        end
    end

    // load responses come back in order
    always @(negedge clk) begin
        if (!rst && lq_en) begin
            if (resp_q.size() == 0) begin
                abort_run("load response with no load waiting for it");
            end else begin
                exp_resp = resp_q.pop_front();
                check_value("load_resp.lq_idx", load_resp.lq_idx, exp_resp.lq_idx);
                check_value("load_resp.data", load_resp.data, exp_resp.data);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (CYCLES_PER_OP * n_ops + 20) @(posedge clk);
        abort_run("timeout, the run did not finish in time");
    end

endmodule

/* dv/dmiss_vectors.txt */
// columns: op a b c d, hex; 1/2 load ok/rejected (addr lq), 3/4 store ok/rejected (addr data mask sc)
// 5 idle (cycles), 6 refill delay, 7 refill (line dirty sc), 8 refill word (idx data), 9 load resp (lq data)
6 00000002 0 0 0
// single load miss
1 00001004 01 0 0
7 00001000 0 0 0
9 01 5a5a1004 0 0
5 00000030 0 0 0
// three loads on one line
1 00002000 02 0 0
1 0000201c 03 0 0
1 00002008 04 0 0
7 00002000 0 0 0
9 02 5a5a2000 0 0
9 03 5a5a201c 0 0
9 04 5a5a2008 0 0
5 00000030 0 0 0
// stores merged into a pending load line
1 00003004 05 0 0
3 00003004 11223344 f 1
3 00003004 aabbccdd 3 2
3 00003010 99887766 8 3
1 00003010 06 0 0
7 00003000 1 3 0
8 1 1122ccdd 0 0
8 4 995a3010 0 0
9 05 1122ccdd 0 0
9 06 995a3010 0 0
5 00000030 0 0 0
// lone store miss
3 00004008 deadbeef 6 4
7 00004000 1 4 0
8 2 5aadbe08 0 0
5 00000030 0 0 0
// entries exhausted, then a store to the locked head
6 0000001e 0 0 0
1 00005000 07 0 0
1 00006000 08 0 0
1 00007000 09 0 0
1 00008000 0a 0 0
2 00009000 0b 0 0
5 00000014 0 0 0
4 00005000 12345678 f 5
7 00005000 0 0 0
7 00006000 0 0 0
7 00007000 0 0 0
7 00008000 0 0 0
9 07 5a5a5000 0 0
9 08 5a5a6000 0 0
9 09 5a5a7000 0 0
9 0a 5a5a8000 0 0
5 00000100 0 0 0
// waiters exhausted on one line
6 00000000 0 0 0
1 0000a000 0c 0 0
1 0000a004 0d 0 0
1 0000a008 0e 0 0
1 0000a00c 0f 0 0
2 0000a010 10 0 0
7 0000a000 0 0 0
9 0c 5a5aa000 0 0
9 0d 5a5aa004 0 0
9 0e 5a5aa008 0 0
9 0f 5a5aa00c 0 0
5 00000030 0 0 0
// long refill back-pressure
6 0000003c 0 0 0
1 0000b014 11 0 0
7 0000b000 0 0 0
9 11 5a5ab014 0 0
5 00000060 0 0 0
0 0 0 0 0

/* sim.f */
common/dmiss_pkg.sv
miss_queue/miss_queue.sv
rtl/load_waiter_table.sv
rtl/line_fill.sv
rtl/dmiss_top.sv
dv/dmiss_tb.sv

/* Bender.yml */
package:
  name: dmiss

sources:
  - common/dmiss_pkg.sv
  - miss_queue/miss_queue.sv
  - rtl/load_waiter_table.sv
  - rtl/line_fill.sv
  - rtl/dmiss_top.sv
  - target: test
    files:
      - dv/dmiss_tb.sv
